/* src.f */
mc_pkg.sv
read_queue.sv
channel_backend.sv
resp_arbiter.sv
mem_ctrl_top.sv
tb_mem_ctrl.sv

/* Makefile */
VERILATOR  = verilator
TOP        = tb_mem_ctrl
FILELIST   = src.f
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing -Wno-fatal
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Test failed" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf obj_dir $(LOG)

/* tb_mem_ctrl.sv */
module tb_mem_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BEATS       = mc_pkg::BURST_BEATS;
    localparam int DEPTH       = mc_pkg::QUEUE_DEPTH;
    localparam int LIMIT       = mc_pkg::SERVE_LIMIT;
    localparam int NIDS        = 2 ** mc_pkg::ID_W;
    localparam int WAIT_LIMIT  = 200;
    localparam int DRAIN_LIMIT = 2000;
    localparam int NSTEPS      = 34;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_IDLE} op_e;

    // Idle rows keep their cycle count in data
    typedef struct {
        op_e           op;
        mc_pkg::addr_t addr;
        mc_pkg::data_t data;
        logic          rnd;
        mc_pkg::id_t   id;
        logic [7:0]    rr;
    } step_t;

    logic           clk;
    logic           rst_n;
    logic           req_valid;
    logic           req_write;
    mc_pkg::addr_t  req_addr;
    mc_pkg::data_t  req_data;
    mc_pkg::id_t    req_id;
    logic [1:0]     req_ready;
    logic           r_ready;
    logic           r_valid;
    mc_pkg::data_t  r_data;
    mc_pkg::id_t    r_id;
    logic           r_last;
    logic           ack_ready;
    logic           b_valid;
    mc_pkg::id_t    b_id;

    // Reference model with expected reads and acks per id
    mc_pkg::data_t ref_mem [2 ** mc_pkg::ADDR_W];
    mc_pkg::addr_t rd_base_q [NIDS][$];
    int            beat_no [NIDS];
    int            ack_cnt [NIDS];
    int            outstanding [2];

    // Burst tracking for interleave, hold and starvation checks
    logic          in_burst = 1'b0;
    mc_pkg::id_t   burst_id;
    int            last_ch = 0;
    int            streak = 0;
    logic          hold_vld = 1'b0;
    mc_pkg::data_t hold_data;
    mc_pkg::id_t   hold_id;

    logic [7:0]    rr_pat;
    int            seed;

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    step_t steps [NSTEPS] = '{
        // Same offset on both channels
        '{OP_WR,   8'h04, 32'h1111_0004, 1'b0, 4'h1, 8'hFF},
        '{OP_WR,   8'h84, 32'h2222_0084, 1'b0, 4'h2, 8'hFF},
        '{OP_RD,   8'h04, 32'h0,         1'b0, 4'h3, 8'hFF},
        '{OP_RD,   8'h84, 32'h0,         1'b0, 4'h4, 8'hFF},
        '{OP_IDLE, 8'h00, 32'd12,        1'b0, 4'h0, 8'hFF},
        // Bursts that wrap inside the channel
        '{OP_WR,   8'h7F, 32'h0,         1'b1, 4'h5, 8'hFF},
        '{OP_WR,   8'hFF, 32'h0,         1'b1, 4'h6, 8'hFF},
        '{OP_RD,   8'h7E, 32'h0,         1'b0, 4'h7, 8'hFF},
        '{OP_RD,   8'hFE, 32'h0,         1'b0, 4'h8, 8'hFF},
        '{OP_IDLE, 8'h00, 32'd12,        1'b0, 4'h0, 8'hFF},
        // Stalls in the middle of a burst
        '{OP_RD,   8'h02, 32'h0,         1'b0, 4'h9, 8'hB5},
        '{OP_RD,   8'h82, 32'h0,         1'b0, 4'hA, 8'hB5},
        '{OP_IDLE, 8'h00, 32'd30,        1'b0, 4'h0, 8'h6C},
        // Both queues loaded while the consumer is stalled
        '{OP_RD,   8'h00, 32'h0,         1'b0, 4'hB, 8'h00},
        '{OP_RD,   8'h01, 32'h0,         1'b0, 4'hC, 8'h00},
        '{OP_RD,   8'h08, 32'h0,         1'b0, 4'hD, 8'h00},
        '{OP_RD,   8'h03, 32'h0,         1'b0, 4'hE, 8'h00},
        '{OP_RD,   8'h80, 32'h0,         1'b0, 4'hF, 8'h00},
        '{OP_RD,   8'h81, 32'h0,         1'b0, 4'h0, 8'h00},
        '{OP_WR,   8'h89, 32'h0,         1'b1, 4'h1, 8'h00},
        '{OP_RD,   8'h88, 32'h0,         1'b0, 4'h2, 8'h00},
        '{OP_RD,   8'hFC, 32'h0,         1'b0, 4'h3, 8'h00},
        '{OP_IDLE, 8'h00, 32'd60,        1'b0, 4'h0, 8'hFF},
        '{OP_RD,   8'h7D, 32'h0,         1'b0, 4'h4, 8'hF3},
        // One read waits on channel 1 while channel 0 keeps refilling
        '{OP_IDLE, 8'h00, 32'd12,        1'b0, 4'h0, 8'hFF},
        '{OP_RD,   8'h88, 32'h0,         1'b0, 4'h5, 8'h00},
        '{OP_RD,   8'h00, 32'h0,         1'b0, 4'h6, 8'h00},
        '{OP_RD,   8'h04, 32'h0,         1'b0, 4'h7, 8'h00},
        '{OP_RD,   8'h08, 32'h0,         1'b0, 4'h8, 8'h00},
        '{OP_RD,   8'h7C, 32'h0,         1'b0, 4'h9, 8'h00},
        '{OP_RD,   8'h02, 32'h0,         1'b0, 4'hA, 8'hFF},
        '{OP_RD,   8'h06, 32'h0,         1'b0, 4'hB, 8'hFF},
        '{OP_RD,   8'h01, 32'h0,         1'b0, 4'hC, 8'hFF},
        '{OP_RD,   8'h05, 32'h0,         1'b0, 4'hD, 8'hFF}
    };

    mem_ctrl_top #(
        .BURST_BEATS(BEATS),
        .QUEUE_DEPTH(DEPTH),
        .SERVE_LIMIT(LIMIT)
    ) dut_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_data(req_data), .req_id(req_id), .req_ready(req_ready),
        .r_ready(r_ready), .r_valid(r_valid), .r_data(r_data), .r_id(r_id),
        .r_last(r_last),
        .ack_ready(ack_ready), .b_valid(b_valid), .b_id(b_id)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Consumer ready follows an 8 cycle pattern taken at each edge
    initial begin : rr_drive
        int   phase;
        logic nxt;
        phase   = 0;
        r_ready = 1'b1;
        forever begin
            @(posedge clk);
            nxt   = rr_pat[phase];
            phase = (phase + 1) % 8;
            #1;
            r_ready = nxt;
        end
    end

    // ------------------------------------------------------------
    // Error reporting and compare tasks
    // ------------------------------------------------------------
    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_on_error($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_ready(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // Expected word is base offset plus beat, wrapped inside the channel
    task automatic check_read(input mc_pkg::id_t id, input mc_pkg::data_t data, input logic last);
        mc_pkg::addr_t   base;
        mc_pkg::offset_t off;
        mc_pkg::addr_t   addr;
        logic            exp_last;
        if (rd_base_q[id].size() == 0)
            report_mismatch($sformatf("read beat for id %0d with no read outstanding", id));
        base     = rd_base_q[id][0];
        off      = mc_pkg::offset_t'(int'(base[mc_pkg::ADDR_W-2:0]) + beat_no[id]);
        addr     = {base[mc_pkg::ADDR_W-1], off};
        exp_last = (beat_no[id] == BEATS - 1);
        if (data !== ref_mem[addr])
            report_mismatch($sformatf("id %0d beat %0d addr %02h data %08h, expected %08h",
                                      id, beat_no[id], addr, data, ref_mem[addr]));
        if (last !== exp_last)
            report_mismatch($sformatf("id %0d beat %0d r_last %b", id, beat_no[id], last));
        if (exp_last) begin
            void'(rd_base_q[id].pop_front());
            beat_no[id] = 0;
        end else begin
            beat_no[id]++;
        end
    endtask

    task automatic check_ack(input mc_pkg::id_t id);
        if (ack_cnt[id] == 0)
            report_mismatch($sformatf("ack for id %0d with no write outstanding", id));
        ack_cnt[id]--;
    endtask

    // ------------------------------------------------------------
    // Monitor samples mid cycle where outputs are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin : monitor
        int ch;
        if (rst_n) begin
            // A stalled beat inside a burst must not move
            if (hold_vld && in_burst && r_valid && (r_data !== hold_data || r_id !== hold_id))
                report_mismatch("read beat changed while r_ready was low");
            hold_vld  = r_valid && !r_ready;
            hold_data = r_data;
            hold_id   = r_id;
            if (r_valid && r_ready) begin
                if (in_burst && r_id !== burst_id)
                    report_mismatch($sformatf("r_id %0d inside burst of id %0d", r_id, burst_id));
                ch = 0;
                if (rd_base_q[r_id].size() > 0)
                    ch = int'(rd_base_q[r_id][0][mc_pkg::ADDR_W-1]);
                check_read(r_id, r_data, r_last);
                if (r_last) begin
                    in_burst = 1'b0;
                    outstanding[ch]--;
                    if (ch != last_ch)
                        streak = 0;
                    last_ch = ch;
                    // Only bursts served while the other side waits count
                    if (outstanding[1-ch] > 0)
                        streak++;
                    else
                        streak = 0;
                    if (streak > LIMIT)
                        stop_on_error($sformatf("Error at %0t ns: channel %0d served %0d bursts %s",
                                                $time, ch, streak, "while the other channel waited"));
                end else begin
                    in_burst = 1'b1;
                    burst_id = r_id;
                end
            end
            if (b_valid && ack_ready)
                check_ack(b_id);
            if (req_valid && !req_write && req_ready[req_addr[mc_pkg::ADDR_W-1]])
                outstanding[req_addr[mc_pkg::ADDR_W-1]]++;
        end
    end

    // ------------------------------------------------------------
    // Driver tasks
    // ------------------------------------------------------------
    function automatic mc_pkg::data_t fill_word(input mc_pkg::addr_t a);
        return {a, ~a, a ^ 8'h3C, 8'hA5};
    endfunction

    function automatic logic traffic_done();
        for (int i = 0; i < NIDS; i++) begin
            if (rd_base_q[i].size() != 0 || ack_cnt[i] != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    // Called 1 ns after an edge, returns 1 ns after the accepting edge
    task automatic issue(input logic wr, input mc_pkg::addr_t addr, input mc_pkg::data_t data,
                         input mc_pkg::id_t id);
        int waited;
        waited = 0;
        while (!req_ready[addr[mc_pkg::ADDR_W-1]]) begin
            waited++;
            if (waited > WAIT_LIMIT)
                stop_on_error($sformatf("Timeout at %0t ns: channel %0d never became ready",
                                        $time, addr[mc_pkg::ADDR_W-1]));
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req_write = wr;
        req_addr  = addr;
        req_data  = data;
        req_id    = id;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (wr) begin
            ref_mem[addr] = data;
            ack_cnt[id]++;
        end else begin
            rd_base_q[id].push_back(addr);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!traffic_done()) begin
            waited++;
            if (waited > DRAIN_LIMIT)
                stop_on_error($sformatf("Timeout at %0t ns: outstanding traffic never finished",
                                        $time));
            @(posedge clk);
            #1;
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : main
        mc_pkg::addr_t a;
        mc_pkg::data_t d;
        seed           = 1353;
        rr_pat         = 8'hFF;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_addr       = '0;
        req_data       = '0;
        req_id         = '0;
        ack_ready      = 1'b1;
        outstanding[0] = 0;
        outstanding[1] = 0;
        for (int i = 0; i < NIDS; i++) begin
            beat_no[i] = 0;
            ack_cnt[i] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle levels out of reset
        @(negedge clk);
        check_bit(r_valid, 1'b0, "r_valid after reset");
        check_bit(b_valid, 1'b0, "b_valid after reset");
        check_ready(req_ready, 2'b11, "req_ready after reset");
        @(posedge clk);
        #1;

        // Preload offsets 7C..0B on both channels
        for (int i = 0; i < 32; i++) begin
            a = {i[0], mc_pkg::offset_t'(124 + i / 2)};
            issue(1'b1, a, fill_word(a), mc_pkg::id_t'(i));
        end
        wait_drain();

        for (int i = 0; i < NSTEPS; i++) begin
            rr_pat = steps[i].rr;
            case (steps[i].op)
                OP_WR: begin
                    d = steps[i].rnd ? mc_pkg::data_t'($random(seed)) : steps[i].data;
                    issue(1'b1, steps[i].addr, d, steps[i].id);
                end
                OP_RD: issue(1'b0, steps[i].addr, '0, steps[i].id);
                default: begin
                    repeat (int'(steps[i].data)) begin
                        @(posedge clk);
                        #1;
                    end
                end
            endcase
        end
        rr_pat = 8'hFF;
        wait_drain();

        // Ack held by the consumer blocks channel 0 only
        ack_ready = 1'b0;
        issue(1'b1, 8'h20, mc_pkg::data_t'($random(seed)), 4'hC);
        repeat (6) begin
            @(negedge clk);
            check_bit(b_valid, 1'b1, "b_valid while ack_ready low");
            check_ready(req_ready, 2'b10, "req_ready with channel 0 ack held");
        end
        @(posedge clk);
        #1;
        ack_ready = 1'b1;
        wait_drain();

        // Fill channel 1 with the consumer stalled
        rr_pat = 8'h00;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        issue(1'b0, 8'h80, '0, 4'h1);
        issue(1'b0, 8'h84, '0, 4'h2);
        issue(1'b0, 8'h88, '0, 4'h3);
        issue(1'b0, 8'hFC, '0, 4'h4);
        @(negedge clk);
        check_ready(req_ready, 2'b01, "req_ready with channel 1 queue full");
        @(posedge clk);
        #1;
        issue(1'b1, 8'h05, mc_pkg::data_t'($random(seed)), 4'h5);
        issue(1'b0, 8'h00, '0, 4'h6);
        @(negedge clk);
        check_bit(req_ready[1], 1'b0, "channel 1 ready with its queue full");
        @(posedge clk);
        #1;
        rr_pat = 8'hFF;
        wait_drain();

        if (outstanding[0] != 0 || outstanding[1] != 0) begin
            stop_on_error($sformatf("Error at %0t ns: read bursts left unfinished", $time));
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* mem_ctrl_top.sv */
module mem_ctrl_top #(
    parameter int BURST_BEATS = mc_pkg::BURST_BEATS,
    parameter int QUEUE_DEPTH = mc_pkg::QUEUE_DEPTH,
    parameter int SERVE_LIMIT = mc_pkg::SERVE_LIMIT
) (
    input  logic           clk,
    input  logic           rst_n,
    // Request port
    input  logic           req_valid,
    input  logic           req_write,
    input  mc_pkg::addr_t  req_addr,
    input  mc_pkg::data_t  req_data,
    input  mc_pkg::id_t    req_id,
    output logic [1:0]     req_ready,
    // Read response
    input  logic           r_ready,
    output logic           r_valid,
    output mc_pkg::data_t  r_data,
    output mc_pkg::id_t    r_id,
    output logic           r_last,
    // Write ack
    input  logic           ack_ready,
    output logic           b_valid,
    output mc_pkg::id_t    b_id
);

    // ------------------------------------------------------------
    // Channel dispatch
    // ------------------------------------------------------------

    logic            ch_sel;
    logic            ch0_req_valid;
    logic            ch1_req_valid;
    mc_pkg::offset_t req_offset;

    assign ch_sel        = req_addr[mc_pkg::ADDR_W-1];
    assign req_offset    = req_addr[mc_pkg::ADDR_W-2:0];
    // Only valid is steered, offset and data fan out to both
    assign ch0_req_valid = req_valid && !ch_sel;
    assign ch1_req_valid = req_valid && ch_sel;

    // Backend to arbiter wires
    logic           ch0_rd_grant, ch1_rd_grant;
    logic           ch0_ack_grant, ch1_ack_grant;
    logic           ch0_rd_valid, ch1_rd_valid;
    logic           ch0_rd_last, ch1_rd_last;
    logic           ch0_ack_valid, ch1_ack_valid;
    mc_pkg::data_t  ch0_rd_data, ch1_rd_data;
    mc_pkg::id_t    ch0_rd_id, ch1_rd_id;
    mc_pkg::id_t    ch0_ack_id, ch1_ack_id;
    mc_pkg::count_t ch0_pending, ch1_pending;

    channel_backend #(
        .BURST_BEATS(BURST_BEATS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) ch0_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(ch0_req_valid), .req_write(req_write), .req_offset(req_offset),
        .req_data(req_data), .req_id(req_id), .req_ready(req_ready[0]),
        .rd_grant(ch0_rd_grant), .pending(ch0_pending), .rd_valid(ch0_rd_valid),
        .rd_data(ch0_rd_data), .rd_id(ch0_rd_id), .rd_last(ch0_rd_last),
        .ack_grant(ch0_ack_grant), .ack_valid(ch0_ack_valid), .ack_id(ch0_ack_id)
    );

    channel_backend #(
        .BURST_BEATS(BURST_BEATS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) ch1_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(ch1_req_valid), .req_write(req_write), .req_offset(req_offset),
        .req_data(req_data), .req_id(req_id), .req_ready(req_ready[1]),
        .rd_grant(ch1_rd_grant), .pending(ch1_pending), .rd_valid(ch1_rd_valid),
        .rd_data(ch1_rd_data), .rd_id(ch1_rd_id), .rd_last(ch1_rd_last),
        .ack_grant(ch1_ack_grant), .ack_valid(ch1_ack_valid), .ack_id(ch1_ack_id)
    );

    // Response arbitration and ack merge
    resp_arbiter #(
        .SERVE_LIMIT(SERVE_LIMIT)
    ) arb_i (
        .clk(clk), .rst_n(rst_n), .r_ready(r_ready), .ack_ready(ack_ready),
        .ch0_rd_valid(ch0_rd_valid), .ch0_rd_data(ch0_rd_data), .ch0_rd_id(ch0_rd_id),
        .ch0_rd_last(ch0_rd_last), .ch0_pending(ch0_pending),
        .ch0_ack_valid(ch0_ack_valid), .ch0_ack_id(ch0_ack_id),
        .ch1_rd_valid(ch1_rd_valid), .ch1_rd_data(ch1_rd_data), .ch1_rd_id(ch1_rd_id),
        .ch1_rd_last(ch1_rd_last), .ch1_pending(ch1_pending),
        .ch1_ack_valid(ch1_ack_valid), .ch1_ack_id(ch1_ack_id),
        .ch0_rd_grant(ch0_rd_grant), .ch1_rd_grant(ch1_rd_grant),
        .ch0_ack_grant(ch0_ack_grant), .ch1_ack_grant(ch1_ack_grant),
        .r_valid(r_valid), .r_data(r_data), .r_id(r_id), .r_last(r_last),
        .b_valid(b_valid), .b_id(b_id)
    );

endmodule

/* resp_arbiter.sv */
module resp_arbiter #(
    parameter int SERVE_LIMIT = mc_pkg::SERVE_LIMIT
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           r_ready,
    input  logic           ack_ready,
    // Channel 0
    input  logic           ch0_rd_valid,
    input  mc_pkg::data_t  ch0_rd_data,
    input  mc_pkg::id_t    ch0_rd_id,
    input  logic           ch0_rd_last,
    input  mc_pkg::count_t ch0_pending,
    input  logic           ch0_ack_valid,
    input  mc_pkg::id_t    ch0_ack_id,
    // Channel 1
    input  logic           ch1_rd_valid,
    input  mc_pkg::data_t  ch1_rd_data,
    input  mc_pkg::id_t    ch1_rd_id,
    input  logic           ch1_rd_last,
    input  mc_pkg::count_t ch1_pending,
    input  logic           ch1_ack_valid,
    input  mc_pkg::id_t    ch1_ack_id,
    // Grants back to the channels
    output logic           ch0_rd_grant,
    output logic           ch1_rd_grant,
    output logic           ch0_ack_grant,
    output logic           ch1_ack_grant,
    // Consumer side
    output logic           r_valid,
    output mc_pkg::data_t  r_data,
    output mc_pkg::id_t    r_id,
    output logic           r_last,
    output logic           b_valid,
    output mc_pkg::id_t    b_id
);

    mc_pkg::arb_state_t state;
    mc_pkg::serve_t     serve_cnt;
    mc_pkg::count_t     cur_pend;
    mc_pkg::count_t     oth_pend;
    mc_pkg::count_t     cur_left;

    logic sel_ch1;
    logic busy;
    logic beat_move;
    logic last_move;
    logic eval;
    logic limit_hit;
    logic switch_ch;

    // ------------------------------------------------------------
    // Read response mux
    // ------------------------------------------------------------

    assign sel_ch1      = (state == mc_pkg::serve_ch1);
    assign ch0_rd_grant = !sel_ch1 && r_ready;
    assign ch1_rd_grant = sel_ch1 && r_ready;

    assign r_valid = sel_ch1 ? ch1_rd_valid : ch0_rd_valid;
    assign r_data  = sel_ch1 ? ch1_rd_data  : ch0_rd_data;
    assign r_id    = sel_ch1 ? ch1_rd_id    : ch0_rd_id;
    assign r_last  = sel_ch1 ? ch1_rd_last  : ch0_rd_last;

    assign beat_move = r_valid && r_ready;
    assign last_move = beat_move && r_last;

    // ------------------------------------------------------------
    // Switch decision
    // ------------------------------------------------------------

    assign cur_pend = sel_ch1 ? ch1_pending : ch0_pending;
    assign oth_pend = sel_ch1 ? ch0_pending : ch1_pending;

    // Reads left on this channel once the finishing burst pops
    assign cur_left = cur_pend - mc_pkg::count_t'(last_move);

    // Count the burst finishing now so the limit holds at the boundary
    assign limit_hit = (int'(serve_cnt) + int'(last_move)) >= SERVE_LIMIT;

    // Only at a burst boundary, never while a first beat leaves
    assign eval = last_move || (!busy && !beat_move);

    assign switch_ch = eval && (oth_pend != '0) &&
                       ((cur_left == '0) || (oth_pend > cur_left) || limit_hit);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mc_pkg::serve_ch0;
        end else if (switch_ch) begin
            state <= sel_ch1 ? mc_pkg::serve_ch0 : mc_pkg::serve_ch1;
        end
    end

    // Burst in progress from first moved beat until last moved beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (last_move) begin
            busy <= 1'b0;
        end else if (beat_move) begin
            busy <= 1'b1;
        end
    end

    // Starvation guard, bursts served back to back on one channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            serve_cnt <= '0;
        end else if (switch_ch) begin
            serve_cnt <= '0;
        end else if (last_move && (serve_cnt != mc_pkg::serve_t'(SERVE_LIMIT))) begin
            serve_cnt <= serve_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Ack merge, channel 1 first
    // ------------------------------------------------------------

    assign b_valid       = ch0_ack_valid || ch1_ack_valid;
    assign b_id          = ch1_ack_valid ? ch1_ack_id : ch0_ack_id;
    assign ch1_ack_grant = ch1_ack_valid && ack_ready;
    // Channel 0 holds its ack while channel 1 drains
    assign ch0_ack_grant = ch0_ack_valid && !ch1_ack_valid && ack_ready;

    // No channel change in the middle of a burst
    a_state_hold : assert property (@(posedge clk) disable iff (!rst_n)
        (busy && !last_move) |=> $stable(state))
        else $error("resp_arbiter: state changed inside a burst");
    a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
        !(ch0_rd_grant && ch1_rd_grant))
        else $error("resp_arbiter: both read grants high");

endmodule

/* channel_backend.sv */
module channel_backend #(
    parameter int BURST_BEATS = mc_pkg::BURST_BEATS,
    parameter int QUEUE_DEPTH = mc_pkg::QUEUE_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,
    // Request from dispatch
    input  logic            req_valid,
    input  logic            req_write,
    input  mc_pkg::offset_t req_offset,
    input  mc_pkg::data_t   req_data,
    input  mc_pkg::id_t     req_id,
    output logic            req_ready,
    // Read burst toward the arbiter
    input  logic            rd_grant,
    output mc_pkg::count_t  pending,
    output logic            rd_valid,
    output mc_pkg::data_t   rd_data,
    output mc_pkg::id_t     rd_id,
    output logic            rd_last,
    // Write acknowledge toward the arbiter
    input  logic            ack_grant,
    output logic            ack_valid,
    output mc_pkg::id_t     ack_id
);

    localparam int WORDS = 2 ** (mc_pkg::ADDR_W - 1);

    // ------------------------------------------------------------
    // Request acceptance
    // ------------------------------------------------------------

    logic wr_take;
    logic rd_take;
    logic q_full;
    logic q_empty;
    logic q_pop;

    mc_pkg::offset_t head_offset;
    mc_pkg::id_t     head_id;
    mc_pkg::offset_t rd_offset;
    mc_pkg::beat_t   beat;

    // Stalls for a full queue or for an ack still waiting on the consumer
    assign req_ready = !q_full && !ack_valid;
    assign wr_take   = req_valid && req_ready && req_write;
    assign rd_take   = req_valid && req_ready && !req_write;

    // ------------------------------------------------------------
    // Word store and write ack
    // ------------------------------------------------------------

    mc_pkg::data_t store [WORDS];

    always_ff @(posedge clk) begin
        if (wr_take) begin
            store[req_offset] <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_take) begin
            ack_id <= req_id;
        end
    end

    // Ack rises the cycle after the write and waits for its grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_valid <= 1'b0;
        end else if (wr_take) begin
            ack_valid <= 1'b1;
        end else if (ack_grant) begin
            ack_valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Read queue and burst generator
    // ------------------------------------------------------------

    read_queue #(
        .DEPTH(QUEUE_DEPTH)
    ) rq_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (rd_take),
        .push_offset(req_offset),
        .push_id    (req_id),
        .pop        (q_pop),
        .head_offset(head_offset),
        .head_id    (head_id),
        .empty      (q_empty),
        .full       (q_full),
        .count      (pending)
    );

    // Head entry stays queued until its last beat leaves,
    // so pending includes the burst in flight
    assign rd_valid  = !q_empty;
    assign rd_id     = head_id;
    assign rd_last   = (beat == mc_pkg::beat_t'(BURST_BEATS - 1));
    // Offset arithmetic wraps inside the channel by width
    assign rd_offset = head_offset + mc_pkg::offset_t'(beat);
    assign rd_data   = store[rd_offset];
    assign q_pop     = rd_valid && rd_grant && rd_last;

    // Beat index only moves on a granted beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= '0;
        end else if (rd_valid && rd_grant) begin
            beat <= rd_last ? '0 : beat + 1'b1;
        end
    end

endmodule

/* read_queue.sv */
module read_queue #(
    parameter int DEPTH = mc_pkg::QUEUE_DEPTH
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  mc_pkg::offset_t push_offset,
    input  mc_pkg::id_t     push_id,
    input  logic            pop,
    output mc_pkg::offset_t head_offset,
    output mc_pkg::id_t     head_id,
    output logic            empty,
    output logic            full,
    output mc_pkg::count_t  count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Entry storage, payload only
    mc_pkg::offset_t offset_mem [DEPTH];
    mc_pkg::id_t     id_mem     [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    assign empty       = (count == '0);
    assign full        = (count == mc_pkg::count_t'(DEPTH));
    assign head_offset = offset_mem[rd_ptr];
    assign head_id     = id_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            offset_mem[wr_ptr] <= push_offset;
            id_mem[wr_ptr]     <= push_id;
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Backend ready gating must keep these from ever firing
    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("read_queue: push while full");
    a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty)
        else $error("read_queue: pop while empty");

endmodule

/* mc_pkg.sv */
package mc_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------

    // Word address, top bit picks the channel
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;

    // ------------------------------------------------------------
    // Default tuning, overridden through the top level
    // ------------------------------------------------------------

    // Beats per read burst
    localparam int BURST_BEATS = 4;
    // Pending read slots per channel
    localparam int QUEUE_DEPTH = 4;
    // Consecutive bursts before the waiting channel gets its turn
    localparam int SERVE_LIMIT = 4;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------

    typedef logic [ADDR_W-1:0] addr_t;
    // Address inside one channel, channel bit stripped
    typedef logic [ADDR_W-2:0] offset_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;

    // Queue occupancy, needs room for 0 .. QUEUE_DEPTH
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;

    // Beat index inside a burst
    typedef logic [$clog2(BURST_BEATS)-1:0] beat_t;

    // Serving counter saturates at SERVE_LIMIT
    typedef logic [$clog2(SERVE_LIMIT+1)-1:0] serve_t;

    // Response arbiter FSM
    typedef enum logic {
        serve_ch0,
        serve_ch1
    } arb_state_t;

endpackage
